// ==== list.f ====
+incdir+bench
rtl/fpconv_pkg.sv
rtl/fp_classify.sv
rtl/fp64_to_fp32.sv
rtl/fp32_to_fp64.sv
rtl/conv_stage.sv
rtl/result_arbiter.sv
rtl/fpconv_top.sv
bench/fpconv_tb.sv

// ==== Makefile ====
SIM      := verilator
SIMFLAGS := --binary --timing -j 0
TOP      := fpconv_tb
FILELIST := list.f

BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) bench/fpconv_model.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== bench/fpconv_model.svh ====
/*
 * Reference float conversions and the xorshift generator for the testbench.
 * Included inside the testbench module after the package import.
 */
`ifndef FPCONV_MODEL_SVH
`define FPCONV_MODEL_SVH

// 32-bit xorshift, shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Double to single, truncating
function automatic logic [31:0] model_narrow(input logic [63:0] d);
    logic                 sign;
    logic [f64_exp_w-1:0] ex;
    logic [f64_man_w-1:0] man;
    logic [f64_man_w:0]   sig;
    int                   e;
    sign = d[63];
    ex   = d[62:52];
    man  = d[51:0];
    e    = int'(ex) - bias_delta;
    // NaN goes quiet, top 23 payload bits kept
    if (&ex && |man) begin
        return {sign, 8'hff, 1'b1, man[50:29]};
    end
    if (&ex) begin
        return {sign, 8'hff, 23'd0};
    end
    // Zero and double denormal both flush
    if (ex == '0) begin
        return {sign, 31'd0};
    end
    if (e > 254) begin
        return {sign, 8'hff, 23'd0};
    end
    if (e >= 1) begin
        return {sign, e[7:0], man[51:29]};
    end
    if (e < -22) begin
        return {sign, 31'd0};
    end
    // Denormal: 29 truncated bits, then one more per step below exponent 1
    sig = {1'b1, man};
    sig = sig >> (29 + (1 - e));
    return {sign, 8'h00, sig[22:0]};
endfunction

// Single to double, exact
function automatic logic [63:0] model_wide(input logic [31:0] s);
    logic        sign;
    logic [7:0]  ex;
    logic [22:0] man;
    logic [63:0] frac;
    int          top;
    sign = s[31];
    ex   = s[30:23];
    man  = s[22:0];
    if (&ex && |man) begin
        return {sign, 11'h7ff, 1'b1, man[21:0], 29'd0};
    end
    if (&ex) begin
        return {sign, 11'h7ff, 52'd0};
    end
    if (ex == 8'd0 && man == 23'd0) begin
        return {sign, 63'd0};
    end
    if (ex == 8'd0) begin
        // Value is man * 2^-149, leading one at bit top
        top = 0;
        for (int i = 0; i < 23; i++) begin
            if (man[i]) begin
                top = i;
            end
        end
        frac = 64'(man) << (52 - top);
        return {sign, 11'(top - 149 + 1023), frac[51:0]};
    end
    return {sign, 11'(int'(ex) + bias_delta), man, 29'd0};
endfunction

`endif

// ==== bench/fpconv_tb.sv ====
/*
 * Testbench for the float conversion unit. Directed and random requests on
 * both ports, results checked in order per path against the reference model.
 */
`timescale 1ns/1ps

module fpconv_tb;
    import fpconv_pkg::*;

    `include "fpconv_model.svh"

    localparam int reset_cycles  = 16;
    localparam int n_rand_narrow = 300;
    localparam int n_special     = 16;
    localparam int n_denorm_each = 4;
    localparam int n_rand_wide   = 200;
    localparam int n_mixed       = 250;
    localparam int total_req     = 1 + n_rand_narrow + n_special + 23 * n_denorm_each
                                   + n_rand_wide + 2 * n_mixed;
    // Four cycles per request plus the reset
    localparam int cycle_limit   = 4 * total_req + reset_cycles;

    logic        clk;
    logic        arst_n;
    logic        n_valid;
    logic        n_ready;
    tag_t        n_tag;
    logic [63:0] n_data;
    logic        w_valid;
    logic        w_ready;
    tag_t        w_tag;
    logic [31:0] w_data;
    logic        r_valid;
    logic        r_ready;
    res_kind_t   r_kind;
    tag_t        r_tag;
    logic [63:0] r_data;

    // One queue of expected results per path
    narrow_item_t narrow_q[$];
    wide_item_t   wide_q[$];

    int          pass_count = 0;
    int          err_count  = 0;
    int          cycles     = 0;
    logic [31:0] rnd_state  = 32'ha2fd_ae99;
    logic [31:0] st_n;
    logic [31:0] st_w;
    logic [31:0] st_r;
    logic        done_n;
    logic        done_w;

    // Alternation tracking after a full stall
    int          alt_state  = 0;
    res_kind_t   alt_kind;
    int          alt_checks = 0;

    int          cov_norm   = 0;
    int          cov_inf    = 0;
    int          cov_denorm = 0;
    int          cov_zero   = 0;

    fpconv_top UUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .n_valid (n_valid),
        .n_ready (n_ready),
        .n_tag   (n_tag),
        .n_data  (n_data),
        .w_valid (w_valid),
        .w_ready (w_ready),
        .w_tag   (w_tag),
        .w_data  (w_data),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .r_kind  (r_kind),
        .r_tag   (r_tag),
        .r_data  (r_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ============================================================
    // Compare tasks
    // ============================================================
    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error: %s expected %h got %h", name, expected, actual);
            err_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_fp32(input string name, input logic [f32_exp_w+f32_man_w:0] expected,
                              input logic [f32_exp_w+f32_man_w:0] actual);
        if (actual !== expected) begin
            $display("error: %s expected %h got %h", name, expected, actual);
            err_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_fp64(input string name, input logic [f64_exp_w+f64_man_w:0] expected,
                              input logic [f64_exp_w+f64_man_w:0] actual);
        if (actual !== expected) begin
            $display("error: %s expected %h got %h", name, expected, actual);
            err_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_tag(input string name, input tag_t expected, input tag_t actual);
        if (actual !== expected) begin
            $display("error: %s expected %h got %h", name, expected, actual);
            err_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_kind(input string name, input res_kind_t expected,
                              input res_kind_t actual);
        if (actual !== expected) begin
            $display("error: %s expected %h got %h", name, expected, actual);
            err_count++;
        end else begin
            pass_count++;
        end
    endtask

    // ============================================================
    // Result scoring
    // ============================================================
    task automatic score_result();
        narrow_item_t n_exp;
        wide_item_t   w_exp;
        // Held item leaves first and the one after it must be the other kind
        if (alt_state == 2) begin
            check_kind("r_kind", alt_kind, r_kind);
            alt_checks++;
            alt_state = 0;
        end else if (alt_state == 1) begin
            alt_state = 2;
        end
        if (r_kind == NARROW) begin
            if (narrow_q.size() == 0) begin
                $display("narrow result with tag %h arrived with no narrow request pending", r_tag);
                err_count++;
            end else begin
                n_exp = narrow_q.pop_front();
                check_tag("r_tag", n_exp.tag, r_tag);
                check_fp32("r_data", n_exp.data, r_data[31:0]);
                check_fp32("r_data[63:32]", 32'd0, r_data[63:32]);
            end
        end else begin
            if (wide_q.size() == 0) begin
                $display("wide result with tag %h arrived with no wide request pending", r_tag);
                err_count++;
            end else begin
                w_exp = wide_q.pop_front();
                check_tag("r_tag", w_exp.tag, r_tag);
                check_fp64("r_data", w_exp.data, r_data);
            end
        end
    endtask

    // Accepts and results as the DUT sees them at the edge
    always @(posedge clk) begin : monitor
        narrow_item_t n_item;
        wide_item_t   w_item;
        if (arst_n) begin
            if (n_valid && n_ready) begin
                n_item.tag  = n_tag;
                n_item.data = model_narrow(n_data);
                narrow_q.push_back(n_item);
            end
            if (w_valid && w_ready) begin
                w_item.tag  = w_tag;
                w_item.data = model_wide(w_data);
                wide_q.push_back(w_item);
            end
            if (r_valid && r_ready) begin
                score_result();
            end else if (r_valid && !n_ready && !w_ready && alt_state == 0) begin
                // Stalled with both stages full
                alt_state = 1;
                alt_kind  = (r_kind == NARROW) ? WIDE : NARROW;
            end
        end
    end

    // ============================================================
    // Stimulus helpers
    // ============================================================
    task automatic next_word(inout logic [31:0] st, output logic [31:0] v);
        st = xorshift32(st);
        v  = st;
    endtask

    // Normal double in the region chosen by a[1:0]
    function automatic logic [63:0] make_double(input logic [31:0] a, input logic [31:0] b,
                                                input logic [31:0] c);
        int e;
        case (a[1:0])
            2'd0:    e = 897 + int'(a[31:8] % 254);
            2'd1:    e = 1151 + int'(a[31:8] % 896);
            2'd2:    e = 874 + int'(a[31:8] % 23);
            default: e = 1 + int'(a[31:8] % 873);
        endcase
        return {c[31], 11'(e), c[19:0], b};
    endfunction

    // Starts on a falling edge and returns on the falling edge after acceptance
    task automatic send_narrow(input logic [63:0] data, input tag_t tag);
        n_valid = 1'b1;
        n_data  = data;
        n_tag   = tag;
        do begin
            @(posedge clk);
        end while (!n_ready);
        @(negedge clk);
        n_valid = 1'b0;
    endtask

    task automatic send_wide(input logic [31:0] data, input tag_t tag);
        w_valid = 1'b1;
        w_data  = data;
        w_tag   = tag;
        do begin
            @(posedge clk);
        end while (!w_ready);
        @(negedge clk);
        w_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (narrow_q.size() != 0 || wide_q.size() != 0 || r_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic end_test(input int num, input string name, input int errs_before);
        $display("test %0d %s finished with %0d errors", num, name, err_count - errs_before);
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] r;
        logic [22:0] man;
        int          errs;
        arst_n  = 1'b0;
        n_valid = 1'b0;
        n_tag   = '0;
        n_data  = '0;
        w_valid = 1'b0;
        w_tag   = '0;
        w_data  = '0;
        r_ready = 1'b1;
        done_n  = 1'b0;
        done_w  = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // Reset state and single request latency
        errs = err_count;
        check_bit("r_valid", 1'b0, r_valid);
        check_bit("n_ready", 1'b1, n_ready);
        check_bit("w_ready", 1'b1, w_ready);
        send_narrow(64'h4009_21fb_5444_2d18, 4'h5);
        check_bit("r_valid", 1'b0, r_valid);
        @(negedge clk);
        // Valid for the transfer two edges after acceptance
        check_bit("r_valid", 1'b1, r_valid);
        wait_drain();
        end_test(1, "reset and latency", errs);

        // Random normal doubles over all four outcomes
        errs = err_count;
        for (int i = 0; i < n_rand_narrow; i++) begin
            next_word(rnd_state, a);
            next_word(rnd_state, b);
            next_word(rnd_state, c);
            r = model_narrow(make_double(a, b, c));
            if (r[30:23] == 8'hff) begin
                cov_inf++;
            end else if (r[30:23] != 8'h00) begin
                cov_norm++;
            end else if (r[22:0] != 23'd0) begin
                cov_denorm++;
            end else begin
                cov_zero++;
            end
            send_narrow(make_double(a, b, c), tag_t'(b[3:0]));
        end
        wait_drain();
        if (cov_norm == 0 || cov_inf == 0 || cov_denorm == 0 || cov_zero == 0) begin
            $display("random narrowing did not reach every outcome class");
            err_count++;
        end
        end_test(2, "narrow random", errs);

        // Special values of both widths
        errs = err_count;
        send_narrow(64'h7ff0_0000_0000_0001, 4'h0);
        send_narrow(64'h7ff4_5678_9abc_def0, 4'h1);
        send_narrow(64'hfff8_0000_1234_5678, 4'h2);
        send_narrow(64'h7ff0_0000_0000_0000, 4'h3);
        send_narrow(64'hfff0_0000_0000_0000, 4'h4);
        send_narrow(64'h0000_0000_0000_0000, 4'h5);
        send_narrow(64'h8000_0000_0000_0000, 4'h6);
        send_narrow(64'h0000_0000_0000_0001, 4'h7);
        send_narrow(64'h800f_ffff_ffff_ffff, 4'h8);
        send_wide(32'h7f80_0001, 4'h9);
        send_wide(32'hff8a_bcde, 4'ha);
        send_wide(32'h7fc1_2345, 4'hb);
        send_wide(32'h7f80_0000, 4'hc);
        send_wide(32'hff80_0000, 4'hd);
        send_wide(32'h0000_0000, 4'he);
        send_wide(32'h8000_0000, 4'hf);
        wait_drain();
        end_test(3, "special values", errs);

        // Denormals for every leading-zero count and then random singles
        errs = err_count;
        for (int lz = 0; lz < 23; lz++) begin
            for (int k = 0; k < n_denorm_each; k++) begin
                next_word(rnd_state, a);
                man = (23'd1 << (22 - lz)) | (a[22:0] & ((23'd1 << (22 - lz)) - 23'd1));
                send_wide({a[31], 8'h00, man}, tag_t'(a[26:23]));
            end
        end
        for (int i = 0; i < n_rand_wide; i++) begin
            next_word(rnd_state, a);
            send_wide(a, tag_t'(a[7:4]));
        end
        wait_drain();
        end_test(4, "widen random", errs);

        // Both paths at once with random back-pressure
        errs = err_count;
        st_n = xorshift32(rnd_state);
        st_w = xorshift32(st_n);
        st_r = xorshift32(st_w);
        rnd_state = st_r;
        fork
            begin : narrow_src
                logic [31:0] x;
                logic [31:0] y;
                logic [31:0] z;
                for (int i = 0; i < n_mixed; i++) begin
                    next_word(st_n, x);
                    next_word(st_n, y);
                    next_word(st_n, z);
                    send_narrow(make_double(x, y, z), tag_t'(y[3:0]));
                    if (z[1:0] == 2'b00) begin
                        @(negedge clk);
                    end
                end
                done_n = 1'b1;
            end
            begin : wide_src
                logic [31:0] x;
                for (int i = 0; i < n_mixed; i++) begin
                    next_word(st_w, x);
                    send_wide(x, tag_t'(x[11:8]));
                    if (x[13:12] == 2'b00) begin
                        @(negedge clk);
                    end
                end
                done_w = 1'b1;
            end
            begin : ready_drv
                logic [31:0] x;
                // Ready held in short runs so stalls can fill both stages
                while (!(done_n && done_w)) begin
                    next_word(st_r, x);
                    r_ready = (x[2:0] >= 3'd3);
                    repeat (1 + int'(x[5:4])) @(negedge clk);
                end
                r_ready = 1'b1;
            end
        join
        wait_drain();
        if (alt_checks == 0) begin
            $display("mixed traffic never stalled with both stages full");
            err_count++;
        end
        end_test(5, $sformatf("mixed traffic, %0d alternation checks", alt_checks), errs);

        $display("checks passed %0d, errors %0d", pass_count, err_count);
        if (err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Run limit
    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with results still outstanding", cycle_limit);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== rtl/fpconv_top.sv ====
/*
 * Float conversion unit top. Narrow and wide request ports feed
 * their converters and stages, merged onto one result bus.
 */
`timescale 1ns/1ps

module fpconv_top (
    input  logic                  clk,
    input  logic                  arst_n,
    // Narrowing requests
    input  logic                  n_valid,
    output logic                  n_ready,
    input  fpconv_pkg::tag_t      n_tag,
    input  logic [63:0]           n_data,
    // Widening requests
    input  logic                  w_valid,
    output logic                  w_ready,
    input  fpconv_pkg::tag_t      w_tag,
    input  logic [31:0]           w_data,
    // Shared result bus
    output logic                  r_valid,
    input  logic                  r_ready,
    output fpconv_pkg::res_kind_t r_kind,
    output fpconv_pkg::tag_t      r_tag,
    output logic [63:0]           r_data
);
    import fpconv_pkg::*;

    logic [31:0]  n_result;
    logic [63:0]  w_result;
    narrow_item_t n_in_item;
    wide_item_t   w_in_item;

    logic         ns_valid;
    logic         ns_ready;
    narrow_item_t ns_item;
    logic         ws_valid;
    logic         ws_ready;
    wide_item_t   ws_item;

    // ============================================================
    // Converters
    // ============================================================
    fp64_to_fp32 u_narrow (
        .fp64_in  (n_data),
        .fp32_out (n_result)
    );

    fp32_to_fp64 u_wide (
        .fp32_in  (w_data),
        .fp64_out (w_result)
    );

    // Tag rides alongside the converted value
    assign n_in_item.tag  = n_tag;
    assign n_in_item.data = n_result;
    assign w_in_item.tag  = w_tag;
    assign w_in_item.data = w_result;

    // ============================================================
    // Stages and arbiter
    // ============================================================
    conv_stage #(
        .item_t(narrow_item_t)
    ) u_n_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (n_valid),
        .in_ready  (n_ready),
        .in_item   (n_in_item),
        .out_valid (ns_valid),
        .out_ready (ns_ready),
        .out_item  (ns_item)
    );

    conv_stage #(
        .item_t(wide_item_t)
    ) u_w_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (w_valid),
        .in_ready  (w_ready),
        .in_item   (w_in_item),
        .out_valid (ws_valid),
        .out_ready (ws_ready),
        .out_item  (ws_item)
    );

    result_arbiter u_arbiter (
        .clk     (clk),
        .arst_n  (arst_n),
        .n_valid (ns_valid),
        .n_ready (ns_ready),
        .n_item  (ns_item),
        .w_valid (ws_valid),
        .w_ready (ws_ready),
        .w_item  (ws_item),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .r_kind  (r_kind),
        .r_tag   (r_tag),
        .r_data  (r_data)
    );

endmodule

// ==== rtl/result_arbiter.sv ====
/*
 * Round-robin merge of the narrow and wide stages onto one
 * registered result bus. Narrow results are zero-extended.
 */
`timescale 1ns/1ps

module result_arbiter (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     n_valid,
    output logic                     n_ready,
    input  fpconv_pkg::narrow_item_t n_item,
    input  logic                     w_valid,
    output logic                     w_ready,
    input  fpconv_pkg::wide_item_t   w_item,
    output logic                     r_valid,
    input  logic                     r_ready,
    output fpconv_pkg::res_kind_t    r_kind,
    output fpconv_pkg::tag_t         r_tag,
    output logic [63:0]              r_data
);
    import fpconv_pkg::*;

    res_kind_t last_q;
    logic      can_load;

    // ============================================================
    // Grant
    // ============================================================
    // Output register free, or its item leaves this cycle
    assign can_load = ~r_valid | r_ready;

    // On a tie the path that did not win last time goes
    assign n_ready = can_load & (~w_valid | (last_q == WIDE));
    assign w_ready = can_load & (~n_valid | (last_q == NARROW));

    // ============================================================
    // Control state
    // ============================================================
    // Reset to WIDE so NARROW wins the first tie
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            r_valid <= 1'b0;
            last_q  <= WIDE;
        end else begin
            if (can_load) begin
                r_valid <= n_valid | w_valid;
            end
            if (n_valid && n_ready) begin
                last_q <= NARROW;
            end else if (w_valid && w_ready) begin
                last_q <= WIDE;
            end
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        if (n_valid && n_ready) begin
            r_kind <= NARROW;
            r_tag  <= n_item.tag;
            r_data <= 64'(n_item.data);
        end else if (w_valid && w_ready) begin
            r_kind <= WIDE;
            r_tag  <= w_item.tag;
            r_data <= w_item.data;
        end
    end

endmodule

// ==== rtl/conv_stage.sv ====
/*
 * One-entry valid/ready register slice for any payload type.
 * Used once per conversion path ahead of the result arbiter.
 */
`timescale 1ns/1ps

module conv_stage #(
    parameter type item_t = logic
) (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  in_valid,
    output logic  in_ready,
    input  item_t in_item,
    output logic  out_valid,
    input  logic  out_ready,
    output item_t out_item
);

    logic  full_q;
    item_t item_q;

    // Room when empty, or when the held item leaves this cycle
    assign in_ready = ~full_q | out_ready;

    // Occupancy flag
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full_q <= 1'b0;
        end else if (in_ready) begin
            full_q <= in_valid;
        end
    end

    // Payload loads on every accepted transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            item_q <= in_item;
        end
    end

    assign out_valid = full_q;
    assign out_item  = item_q;

endmodule

// ==== rtl/fp32_to_fp64.sv ====
/*
 * Single to double widening, combinational and always exact.
 * Single denormals come out as normalized doubles.
 */
`timescale 1ns/1ps

module fp32_to_fp64 (
    input  logic [31:0] fp32_in,
    output logic [63:0] fp64_out
);
    import fpconv_pkg::*;

    logic                 is_nan;
    logic                 is_inf;
    logic                 is_zero;
    logic                 is_denorm;

    logic                 sign;
    logic [f32_exp_w-1:0] exp_in;
    logic [f32_man_w-1:0] man_in;

    logic [4:0]           lz;
    logic [f32_man_w-1:0] norm_man;
    logic [f64_exp_w-1:0] norm_exp;
    logic [f64_exp_w-1:0] denorm_exp;

    // ============================================================
    // Input classification
    // ============================================================
    fp_classify #(
        .width(32)
    ) u_classify (
        .value     (fp32_in),
        .is_nan    (is_nan),
        .is_snan   (),
        .is_inf    (is_inf),
        .is_zero   (is_zero),
        .is_denorm (is_denorm),
        .is_norm   ()
    );

    assign sign   = fp32_in[31];
    assign exp_in = fp32_in[30 -: f32_exp_w];
    assign man_in = fp32_in[f32_man_w-1:0];

    // Normal exponent onto the double bias
    assign norm_exp = {3'b000, exp_in} + f64_exp_w'(bias_delta);

    // ============================================================
    // Denormal normalization
    // ============================================================
    // Leading-zero count, the highest set bit wins as the scan goes up
    always_comb begin
        lz = 5'd0;
        for (int i = 0; i < f32_man_w; i++) begin
            if (man_in[i]) begin
                lz = 5'(f32_man_w - 1 - i);
            end
        end
    end

    // Leading one moves past the top and becomes the hidden bit
    assign norm_man = man_in << 5'(lz + 5'd1);

    // MSB at bit 22 means 2^-127, i.e. double exponent 896
    assign denorm_exp = f64_exp_w'(bias_delta) - f64_exp_w'(lz);

    // ============================================================
    // Result selection
    // ============================================================
    always_comb begin
        if (is_nan) begin
            // Force quiet, payload into the top of the double mantissa
            fp64_out = {sign, 11'h7ff, 1'b1, man_in[f32_man_w-2:0], 29'd0};
        end else if (is_inf) begin
            fp64_out = {sign, 11'h7ff, 52'd0};
        end else if (is_zero) begin
            fp64_out = {sign, 63'd0};
        end else if (is_denorm) begin
            fp64_out = {sign, denorm_exp, norm_man, 29'd0};
        end else begin
            fp64_out = {sign, norm_exp, man_in, 29'd0};
        end
    end

endmodule

// ==== rtl/fp64_to_fp32.sv ====
/*
 * Double to single narrowing, combinational. Truncates the mantissa,
 * saturates overflow to infinity and shifts small values to denormals.
 */
`timescale 1ns/1ps

module fp64_to_fp32 (
    input  logic [63:0] fp64_in,
    output logic [31:0] fp32_out
);
    import fpconv_pkg::*;

    logic                 is_nan;
    logic                 is_inf;
    logic                 is_zero;
    logic                 is_denorm;

    logic                 sign;
    logic [f64_exp_w-1:0] exp_in;
    logic [f64_man_w-1:0] man_in;

    // Rebiased exponent, two guard bits keep the sign
    logic signed [12:0]   new_exp;
    logic [f64_man_w:0]   full_man;
    logic [5:0]           shift;
    logic [f64_man_w:0]   shifted;

    // ============================================================
    // Input classification
    // ============================================================
    fp_classify #(
        .width(64)
    ) u_classify (
        .value     (fp64_in),
        .is_nan    (is_nan),
        .is_snan   (),
        .is_inf    (is_inf),
        .is_zero   (is_zero),
        .is_denorm (is_denorm),
        .is_norm   ()
    );

    assign sign   = fp64_in[63];
    assign exp_in = fp64_in[62 -: f64_exp_w];
    assign man_in = fp64_in[f64_man_w-1:0];

    // Exponent moved onto the single bias
    assign new_exp = $signed({2'b00, exp_in}) - $signed(13'(bias_delta));

    // Hidden one restored for the denormal path
    assign full_man = {1'b1, man_in};

    // 29 bits dropped by truncation plus one per step below exponent 1
    assign shift   = 6'(13'sd30 - new_exp);
    assign shifted = full_man >> shift;

    // ============================================================
    // Result selection, in priority order
    // ============================================================
    always_comb begin
        if (is_nan) begin
            // Quiet NaN, top payload bits kept
            fp32_out = {sign, 8'hff, 1'b1, man_in[f64_man_w-2 -: f32_man_w-1]};
        end else if (is_inf) begin
            fp32_out = {sign, 8'hff, 23'd0};
        end else if (is_zero || is_denorm) begin
            // Double denormals are far below single range
            fp32_out = {sign, 31'd0};
        end else if (new_exp > 13'sd254) begin
            // Too large for a single
            fp32_out = {sign, 8'hff, 23'd0};
        end else if (new_exp < -13'sd22) begin
            // Even the hidden one shifts out
            fp32_out = {sign, 31'd0};
        end else if (new_exp < 13'sd1) begin
            fp32_out = {sign, 8'h00, shifted[f32_man_w-1:0]};
        end else begin
            // Normal, low mantissa bits dropped
            fp32_out = {sign, new_exp[f32_exp_w-1:0], man_in[f64_man_w-1 -: f32_man_w]};
        end
    end

endmodule

// ==== rtl/fp_classify.sv ====
/*
 * IEEE-754 class decoder for singles or doubles, picked by width.
 * Purely combinational, one instance per converter input.
 */
`timescale 1ns/1ps

module fp_classify #(
    parameter int width = 64
) (
    input  logic [width-1:0] value,
    output logic             is_nan,
    output logic             is_snan,
    output logic             is_inf,
    output logic             is_zero,
    output logic             is_denorm,
    output logic             is_norm
);
    import fpconv_pkg::*;

    // Field widths follow the chosen format
    localparam int exp_w = (width == 64) ? f64_exp_w : f32_exp_w;
    localparam int man_w = (width == 64) ? f64_man_w : f32_man_w;

    logic [exp_w-1:0] exp_f;
    logic [man_w-1:0] man_f;
    logic             exp_ones;
    logic             exp_zero;
    logic             man_zero;

    // ============================================================
    // Field decode
    // ============================================================
    // Sign bit sits above the exponent and plays no part in the class
    assign exp_f = value[width-2 -: exp_w];
    assign man_f = value[man_w-1:0];

    assign exp_ones = &exp_f;
    assign exp_zero = ~|exp_f;
    assign man_zero = ~|man_f;

    // ============================================================
    // Class flags
    // ============================================================
    // All-ones exponent: infinity or NaN
    assign is_nan = exp_ones & ~man_zero;
    assign is_inf = exp_ones & man_zero;

    // Signalling NaN has the mantissa MSB clear
    assign is_snan = is_nan & ~man_f[man_w-1];

    // Zero exponent: zero or denormal
    assign is_zero   = exp_zero & man_zero;
    assign is_denorm = exp_zero & ~man_zero;

    // Anything else is a normal number
    assign is_norm = ~exp_ones & ~exp_zero;

endmodule

// ==== rtl/fpconv_pkg.sv ====
/*
 * Shared format widths, tag type and stage payload items for the
 * float conversion unit. Compile this before any other RTL file.
 */
package fpconv_pkg;

    // ============================================================
    // Format field widths
    // ============================================================
    localparam int tag_w     = 4;
    localparam int f64_exp_w = 11;
    localparam int f64_man_w = 52;
    localparam int f32_exp_w = 8;
    localparam int f32_man_w = 23;

    // Double bias minus single bias (1023 - 127)
    localparam int bias_delta = 896;

    // ============================================================
    // Types
    // ============================================================
    typedef logic [tag_w-1:0] tag_t;

    // Narrowing path payload, single precision result
    typedef struct packed {
        tag_t                           tag;
        logic [f32_exp_w+f32_man_w:0]   data;
    } narrow_item_t;

    // Widening path payload, double precision result
    typedef struct packed {
        tag_t                           tag;
        logic [f64_exp_w+f64_man_w:0]   data;
    } wide_item_t;

    // Which path produced a result
    typedef enum logic {
        NARROW = 1'b0,
        WIDE   = 1'b1
    } res_kind_t;

endpackage
